/* tb/tf_tests.dat */
// First word is the test count. Then per line: opcode depth, data lanes 0..3,
// index lanes 0..3, expected lanes 0..3 (steps only). Opcodes 0 base, 1 const, 2 step.
0010
0002 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
0001 0000 0002 0003 0005 0007 0000 0001 0002 0003 0000 0000 0000 0000
0001 0000 0064 03E8 3000 000B 0004 0005 0006 0007 0000 0000 0000 0000
0000 0001 000A 0014 001E 0028 0000 0000 0000 0000 0000 0000 0000 0000
0000 0002 3000 1770 0001 270F 0000 0000 0000 0000 0000 0000 0000 0000
0000 0003 0005 0006 0007 0008 0000 0000 0000 0000 0000 0000 0000 0000
0000 0000 0001 0002 0003 0004 0000 0000 0000 0000 0000 0000 0000 0000
0002 0001 0000 0000 0000 0000 0000 0001 0002 0003 0014 003C 0096 0118
0002 0001 0000 0000 0000 0000 0001 0001 0001 0001 003C 00B4 01C2 0348
0002 0002 0000 0000 0000 0000 0006 0005 0004 0007 0001 0B98 0064 2D9D
0002 0000 0000 0000 0000 0000 0000 0000 0000 0000 0002 0004 0006 0008
0002 0003 0000 0000 0000 0000 0004 0004 0004 0004 01F4 0258 02BC 0320
0002 0001 0000 0000 0000 0000 0002 0002 0002 0002 012C 0384 08CA 1068
0002 0002 0000 0000 0000 0000 0000 0000 0000 0000 0002 1730 00C8 2B39
0001 0000 0009 0011 0028 0032 0001 0001 0005 0005 0000 0000 0000 0000
0002 0003 0000 0000 0000 0000 0001 0005 0001 0005 2134 152E 2E7C 0C3D

/* list.f */
verilog/tf_pkg.sv
verilog/tf_stage_if.sv
verilog/tf_table_stage.sv
verilog/barrett_lane.sv
verilog/tf_mul_stage.sv
verilog/tf_output_stage.sv
verilog/tf_gen_top.sv
tb/tf_gen_tb.sv

/* tb/tf_gen_tb.sv */
`timescale 1ns/1ps

module tf_gen_tb
	import tf_pkg::*;
;

	localparam int FIELDS = 14;
	localparam int MAX_TESTS = 32;
	localparam int TIMEOUT = 200;

	logic clk;
	logic rst;
	logic cmd_valid;
	logic cmd_ready;
	tf_op_e cmd_op;
	depth_t cmd_depth;
	row_t cmd_data;
	idx_row_t cmd_idx;
	logic res_valid;
	logic res_ready;
	row_t res_data;
	depth_t res_depth;

	logic [15:0] vec [0:FIELDS*MAX_TESTS];
	word_t base_m [DEPTH_ROWS][NUM_LANES];
	word_t cst_m [CONST_ENTRIES];
	row_t exp_q [$];
	depth_t dep_q [$];
	int num_q [$];
	int pass_count = 0;
	int fail_count = 0;
	logic timed_out = 1'b0;
	integer seed = 32'h5823;

	tf_gen_top u_tf_gen_top (
		.clk(clk), .rst(rst), .cmd_valid(cmd_valid), .cmd_ready(cmd_ready),
		.cmd_op(cmd_op), .cmd_depth(cmd_depth), .cmd_data(cmd_data), .cmd_idx(cmd_idx),
		.res_valid(res_valid), .res_ready(res_ready), .res_data(res_data),
		.res_depth(res_depth)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// Holds the command until cmd_ready is seen, sampled 3 ns into the cycle.
	task automatic send_command(output logic lost);
		int waited;
		waited = 0;
		lost = 1'b0;
		cmd_valid = 1'b1;
		#1;
		while (!cmd_ready && waited < TIMEOUT) begin
			@(posedge clk);
			#3;
			waited++;
		end
		if (!cmd_ready) begin
			lost = 1'b1;
		end else begin
			@(posedge clk);
			#2;
		end
		cmd_valid = 1'b0;
	endtask

	// Consumer with random stalls. Checks hold stability and the result order.
	initial begin
		int hold;
		logic fresh;
		row_t held;
		hold = 0;
		fresh = 1'b1;
		res_ready = 1'b1;
		@(negedge rst);
		forever begin
			@(posedge clk);
			#2;
			if (res_valid && fresh) begin
				hold = {$random(seed)} % 4;
				held = res_data;
				fresh = 1'b0;
			end
			if (res_valid && hold > 0) begin
				res_ready = 1'b0;
				hold--;
				if (res_data !== held) begin
					$display("FAILED at %0t: res_data changed during stall, expected %h got %h",
						$time, held, res_data);
					fail_count++;
				end
			end else begin
				res_ready = 1'b1;
				if (res_valid) begin
					fresh = 1'b1;
					if (exp_q.size() == 0) begin
						$display("A result arrived with no step outstanding at %0t.", $time);
						fail_count++;
					end else if (res_data !== exp_q[0]) begin
						$display("FAILED at %0t: res_data expected %h got %h",
							$time, exp_q[0], res_data);
						fail_count++;
					end else if (res_depth !== dep_q[0]) begin
						$display("FAILED at %0t: res_depth expected %0d got %0d",
							$time, dep_q[0], res_depth);
						fail_count++;
					end else begin
						$display("test %0d step depth %0d ok", num_q[0], dep_q[0]);
						pass_count++;
					end
					if (exp_q.size() != 0) begin
						void'(exp_q.pop_front());
						void'(dep_q.pop_front());
						void'(num_q.pop_front());
					end
				end
			end
		end
	end

	initial begin
		int n;
		int b;
		int waited;
		logic lost;
		row_t model_row;
		row_t file_row;
		cmd_valid = 1'b0;
		cmd_op = op_load_base;
		cmd_depth = '0;
		cmd_data = '0;
		cmd_idx = '0;
		foreach (base_m[d, i]) base_m[d][i] = '0;
		foreach (cst_m[c]) cst_m[c] = '0;
		$readmemh("tb/tf_tests.dat", vec);
		rst = 1'b1;
		repeat (3) @(posedge clk);
		#2;
		rst = 1'b0;
		if (cmd_ready !== 1'b1) begin
			$display("FAILED at %0t: cmd_ready expected 1 got %b", $time, cmd_ready);
			fail_count++;
		end
		if (res_valid !== 1'b0) begin
			$display("FAILED at %0t: res_valid expected 0 got %b", $time, res_valid);
			fail_count++;
		end
		n = vec[0];
		for (int t = 0; t < n && !timed_out; t++) begin
			b = 1 + t * FIELDS;
			cmd_op = tf_op_e'(vec[b][1:0]);
			cmd_depth = vec[b+1][DEPTH_W-1:0];
			for (int i = 0; i < NUM_LANES; i++) begin
				cmd_data[i] = vec[b+2+i];
				cmd_idx[i] = vec[b+6+i][IDX_W-1:0];
				file_row[i] = vec[b+10+i];
			end
			if (cmd_op == op_step) begin
				for (int i = 0; i < NUM_LANES; i++) begin
					model_row[i] = word_t'((int'(base_m[cmd_depth][i]) *
						int'(cst_m[cmd_idx[i]])) % int'(MODULUS));
					base_m[cmd_depth][i] = model_row[i];
				end
				if (model_row !== file_row) begin
					$display("Data error in test %0d: file expects %h, model gives %h.",
						t, file_row, model_row);
					fail_count++;
				end
				exp_q.push_back(model_row);
				dep_q.push_back(cmd_depth);
				num_q.push_back(t);
			end else if (cmd_op == op_load_const) begin
				for (int i = 0; i < NUM_LANES; i++) begin
					cst_m[cmd_idx[i]] = cmd_data[i]; // Lane order makes the higher lane win.
				end
			end else begin
				for (int i = 0; i < NUM_LANES; i++) begin
					base_m[cmd_depth][i] = cmd_data[i];
				end
			end
			send_command(lost);
			if (lost) begin
				$display("Test %0d timed out waiting for cmd_ready.", t);
				timed_out = 1'b1;
			end else if (cmd_op != op_step) begin
				$display("test %0d load accepted", t);
				pass_count++;
			end
		end
		waited = 0;
		while (exp_q.size() != 0 && waited < TIMEOUT) begin
			@(posedge clk);
			waited++;
		end
		if (exp_q.size() != 0) begin
			$display("Timed out waiting for %0d outstanding results.", exp_q.size());
			timed_out = 1'b1;
		end
		repeat (4) @(posedge clk);
		$display("Summary: %0d passed, %0d failed", pass_count, fail_count);
		if (fail_count == 0 && !timed_out) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

/* verilog/tf_gen_top.sv */
`timescale 1ns/1ps

module tf_gen_top
	import tf_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic cmd_valid,
	output logic cmd_ready,
	input tf_op_e cmd_op,
	input depth_t cmd_depth,
	input row_t cmd_data,
	input idx_row_t cmd_idx,
	output logic res_valid,
	input logic res_ready,
	output row_t res_data,
	output depth_t res_depth
);

	logic wb_en;
	depth_t wb_depth;
	row_t wb_data;

	tf_stage_if opnd ();
	tf_stage_if prod ();

	tf_table_stage u_table (
		.clk(clk),
		.rst(rst),
		.cmd_valid(cmd_valid),
		.cmd_op(cmd_op),
		.cmd_depth(cmd_depth),
		.cmd_data(cmd_data),
		.cmd_idx(cmd_idx),
		.wb_en(wb_en),
		.wb_depth(wb_depth),
		.wb_data(wb_data),
		.cmd_ready(cmd_ready),
		.opnd(opnd.src)
	);

	tf_mul_stage u_mul (
		.clk(clk),
		.rst(rst),
		.opnd(opnd.dst),
		.prod(prod.src)
	);

	tf_output_stage u_out (
		.clk(clk),
		.rst(rst),
		.res_ready(res_ready),
		.res_valid(res_valid),
		.res_data(res_data),
		.res_depth(res_depth),
		.wb_en(wb_en),
		.wb_depth(wb_depth),
		.wb_data(wb_data),
		.prod(prod.dst)
	);

endmodule

/* verilog/tf_output_stage.sv */
`timescale 1ns/1ps

module tf_output_stage
	import tf_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic res_ready,
	output logic res_valid,
	output row_t res_data,
	output depth_t res_depth,
	output logic wb_en,
	output depth_t wb_depth,
	output row_t wb_data,
	tf_stage_if.dst prod
);

	logic load;

	assign prod.ready = !res_valid || res_ready;
	assign load = prod.valid && prod.ready;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			res_valid <= 1'b0;
			wb_en <= 1'b0;
		end else begin
			if (prod.ready) begin
				res_valid <= prod.valid;
			end
			wb_en <= load; // One write-back per result, even when the consumer stalls.
		end
	end

	always_ff @(posedge clk) begin
		if (load) begin
			res_data <= prod.base;
			res_depth <= prod.depth;
		end
	end

	assign wb_data = res_data;
	assign wb_depth = res_depth;

	a_res_hold: assert property (@(posedge clk) disable iff (rst)
		res_valid && !res_ready |=> $stable(res_data) && $stable(res_depth));

endmodule

/* verilog/tf_mul_stage.sv */
`timescale 1ns/1ps

module tf_mul_stage
	import tf_pkg::*;
(
	input logic clk,
	input logic rst,
	tf_stage_if.dst opnd,
	tf_stage_if.src prod
);

	logic en;
	row_t prod_row;
	logic [MUL_LATENCY-1:0] vld_pipe;
	depth_t dep_pipe [MUL_LATENCY];

	assign en = prod.ready; // One enable moves the lanes and the side pipe together.
	assign opnd.ready = prod.ready;

	for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
		barrett_lane u_lane (
			.clk(clk),
			.rst(rst),
			.en(en),
			.a(opnd.base[i]),
			.b(opnd.cst[i]),
			.result(prod_row[i])
		);
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			vld_pipe <= '0;
		end else if (en) begin
			vld_pipe <= {vld_pipe[MUL_LATENCY-2:0], opnd.valid};
		end
	end

	always_ff @(posedge clk) begin
		if (en) begin
			dep_pipe[0] <= opnd.depth;
			for (int s = 1; s < MUL_LATENCY; s++) begin
				dep_pipe[s] <= dep_pipe[s-1];
			end
		end
	end

	assign prod.valid = vld_pipe[MUL_LATENCY-1];
	assign prod.depth = dep_pipe[MUL_LATENCY-1];
	assign prod.base = prod_row;

endmodule

/* verilog/barrett_lane.sv */
`timescale 1ns/1ps

module barrett_lane
	import tf_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic en,
	input word_t a,
	input word_t b,
	output word_t result
);

	logic [PROD_W-1:0] prod_s1;
	logic [PROD_W-1:0] prod_s2;
	logic [Q_W-1:0] q_s2;
	logic [PROD_W+MU_W-1:0] prod_mu;
	logic [PROD_W-1:0] r0;
	logic [PROD_W-1:0] r1;
	logic [PROD_W-1:0] r2;

	assign prod_mu = prod_s1 * BARRETT_MU;

	// The estimate is at most two short of the true quotient.
	assign r0 = prod_s2 - q_s2 * MODULUS;
	assign r1 = (r0 >= MODULUS) ? r0 - MODULUS : r0;
	assign r2 = (r1 >= MODULUS) ? r1 - MODULUS : r1;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			prod_s1 <= '0;
			prod_s2 <= '0;
			q_s2 <= '0;
			result <= '0;
		end else if (en) begin
			prod_s1 <= a * b;
			prod_s2 <= prod_s1;
			q_s2 <= prod_mu[PROD_W+MU_W-1:BARRETT_K];
			result <= r2[WORD_W-1:0];
		end
	end

	// Holds as long as both operands were already reduced.
	a_result_reduced: assert property (@(posedge clk) disable iff (rst)
		en |=> result < MODULUS);

endmodule

/* verilog/tf_table_stage.sv */
`timescale 1ns/1ps

module tf_table_stage
	import tf_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic cmd_valid,
	input tf_op_e cmd_op,
	input depth_t cmd_depth,
	input row_t cmd_data,
	input idx_row_t cmd_idx,
	input logic wb_en,
	input depth_t wb_depth,
	input row_t wb_data,
	output logic cmd_ready,
	tf_stage_if.src opnd
);

	row_t base_tab [DEPTH_ROWS];
	word_t cst_tab [CONST_ENTRIES];
	logic [DEPTH_ROWS-1:0] pending;

	logic accept;
	logic is_load_base;
	logic is_load_const;
	logic is_step;
	logic step_go;

	// A row with a product still in the pipe is locked for every opcode.
	assign cmd_ready = opnd.ready && !pending[cmd_depth];
	assign accept = cmd_valid && cmd_ready;

	assign is_load_base = (cmd_op == op_load_base);
	assign is_load_const = (cmd_op == op_load_const);
	assign is_step = (cmd_op == op_step);
	assign step_go = accept && is_step;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			for (int d = 0; d < DEPTH_ROWS; d++) begin
				base_tab[d] <= '0;
			end
			for (int c = 0; c < CONST_ENTRIES; c++) begin
				cst_tab[c] <= '0;
			end
		end else begin
			if (wb_en) begin
				base_tab[wb_depth] <= wb_data; // Stepped row replaces its base.
			end
			if (accept && is_load_base) begin
				base_tab[cmd_depth] <= cmd_data;
			end
			if (accept && is_load_const) begin
				for (int i = 0; i < NUM_LANES; i++) begin
					cst_tab[cmd_idx[i]] <= cmd_data[i]; // Later lanes overwrite earlier ones.
				end
			end
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			pending <= '0;
		end else begin
			if (wb_en) begin
				pending[wb_depth] <= 1'b0;
			end
			if (step_go) begin
				pending[cmd_depth] <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			opnd.valid <= 1'b0;
		end else if (opnd.ready) begin
			opnd.valid <= step_go;
		end
	end

	// The lanes multiply these even when no step is in flight.
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			opnd.depth <= '0;
			opnd.base <= '0;
			opnd.cst <= '0;
		end else if (step_go) begin
			opnd.depth <= cmd_depth;
			opnd.base <= base_tab[cmd_depth];
			for (int i = 0; i < NUM_LANES; i++) begin
				opnd.cst[i] <= cst_tab[cmd_idx[i]];
			end
		end
	end

	// The output stage must only return rows that this stage sent out.
	a_wb_pending: assert property (@(posedge clk) disable iff (rst)
		wb_en |-> pending[wb_depth]);

endmodule

/* verilog/tf_stage_if.sv */
`timescale 1ns/1ps

interface tf_stage_if
	import tf_pkg::*;
;

	logic valid;
	logic ready;
	depth_t depth;
	row_t base; // Base row, or the product row on the second hop.
	row_t cst;

	modport src (
		output valid,
		output depth,
		output base,
		output cst,
		input ready
	);

	modport dst (
		input valid,
		input depth,
		input base,
		input cst,
		output ready
	);

endinterface

/* verilog/tf_pkg.sv */
package tf_pkg;

	localparam int WORD_W = 16;
	localparam int NUM_LANES = 4;
	localparam int DEPTH_ROWS = 4;
	localparam int CONST_ENTRIES = 8;
	localparam int DEPTH_W = 2;
	localparam int IDX_W = 3;

	// The multiplier pipe is product, quotient estimate, then correction.
	localparam int MUL_LATENCY = 3;

	localparam int PROD_W = 2 * WORD_W;
	localparam int BARRETT_K = 28;
	localparam int MU_W = 15;
	localparam int Q_W = PROD_W + MU_W - BARRETT_K;

	typedef logic [WORD_W-1:0] word_t;
	typedef logic [NUM_LANES-1:0][WORD_W-1:0] row_t;
	typedef logic [NUM_LANES-1:0][IDX_W-1:0] idx_row_t;
	typedef logic [DEPTH_W-1:0] depth_t;

	localparam word_t MODULUS = 16'd12289;

	// Floor of 2^K over the modulus, which is 21843 for q = 12289.
	localparam logic [MU_W-1:0] BARRETT_MU = MU_W'((64'd1 << BARRETT_K) / MODULUS);

	typedef enum logic [1:0] {
		op_load_base = 2'd0,
		op_load_const = 2'd1,
		op_step = 2'd2
	} tf_op_e;

endpackage
